/* Makefile */
# Verilator flow for the rank-mapping engine

OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

# RTL only, top level he_top
lint:
	verilator --lint-only -Wall --top-module he_top \
		he_pkg.sv he_ctrl.sv ref_loader.sv rank_lane.sv out_drain.sv he_top.sv

# Build and run the testbench, fail unless the pass line shows up
sim:
	verilator --binary --timing --assert --top-module tb_he -Mdir $(OBJ) -f build.f
	out="$$(./$(OBJ)/Vtb_he)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ)

/* build.f */
he_pkg.sv
he_ctrl.sv
ref_loader.sv
rank_lane.sv
out_drain.sv
he_top.sv
tb_he.sv

/* he_ctrl.sv */
// Phase controller for the rank-mapping engine
// Sequences reference loading, sample accumulation and result draining
// Outputs are decoded straight from the state and in_valid

`timescale 1ns/10ps

module he_ctrl (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            load_en,
	output logic            clear,
	output logic            count_en,
	output logic            drain_en,
	output he_pkg::idx_t    drain_idx
);

	// --------------------
	// State and counter
	// --------------------

	he_pkg::he_state_t state;
	he_pkg::he_state_t state_nxt;

	// Loaded references in LOAD, drained lanes in DRAIN
	he_pkg::idx_t cnt;
	he_pkg::idx_t cnt_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= he_pkg::ST_IDLE;
			cnt   <= '0;
		end else begin
			state <= state_nxt;
			cnt   <= cnt_nxt;
		end
	end

	// --------------------
	// Next state and strobes
	// --------------------

	always_comb begin
		state_nxt = state;
		cnt_nxt   = cnt;
		load_en   = 1'b0;
		clear     = 1'b0;
		count_en  = 1'b0;
		drain_en  = 1'b0;

		case (state)
			he_pkg::ST_IDLE: begin
				// First pixel of a burst is reference 0
				if (in_valid) begin
					load_en   = 1'b1;
					// Old counts go away on the same edge
					clear     = 1'b1;
					cnt_nxt   = he_pkg::idx_t'(1);
					state_nxt = he_pkg::ST_LOAD;
				end
			end

			he_pkg::ST_LOAD: begin
				// Low in_valid just pauses loading
				if (in_valid) begin
					load_en = 1'b1;
					// Last lane index ends the load
					if (cnt == he_pkg::idx_t'(he_pkg::LANES - 1)) begin
						// Eighth reference taken
						cnt_nxt   = '0;
						state_nxt = he_pkg::ST_ACCUM;
					end else begin
						cnt_nxt = cnt + 1'b1;
					end
				end
			end

			he_pkg::ST_ACCUM: begin
				// Every valid pixel here is a sample
				count_en = in_valid;
				// Burst over, drain starts next cycle
				if (!in_valid) begin
					cnt_nxt   = '0;
					state_nxt = he_pkg::ST_DRAIN;
				end
			end

			he_pkg::ST_DRAIN: begin
				// in_valid ignored while results go out
				drain_en = 1'b1;
				// Last lane index ends the drain
				if (cnt == he_pkg::idx_t'(he_pkg::LANES - 1)) begin
					cnt_nxt   = '0;
					state_nxt = he_pkg::ST_IDLE;
				end else begin
					cnt_nxt = cnt + 1'b1;
				end
			end

			default: begin
				cnt_nxt   = '0;
				state_nxt = he_pkg::ST_IDLE;
			end
		endcase
	end

	// Counter doubles as the lane select
	assign drain_idx = cnt;

endmodule

/* he_pkg.sv */
// Shared definitions for the rank-mapping engine
// Pixel and count widths, lane count, saturation limit and FSM states

package he_pkg;

	// --------------------
	// Widths and sizes
	// --------------------

	// Pixel width in bits
	localparam int PIX_W = 8;

	// Reference pixels held per burst, one rank lane each
	localparam int LANES = 8;

	// Enough bits to address any lane
	localparam int IDX_W = 3;

	// Rank counter width
	localparam int CNT_W = 8;

	// --------------------
	// Types
	// --------------------

	typedef logic [PIX_W-1:0] pix_t;
	typedef logic [CNT_W-1:0] cnt_t;
	typedef logic [IDX_W-1:0] idx_t;

	// Count stops here and holds
	localparam cnt_t CNT_MAX = cnt_t'(255);

	// Phases of one burst
	typedef enum logic [1:0] {
		// Waiting for the first pixel
		ST_IDLE  = 2'b00,
		// Filling the reference register
		ST_LOAD  = 2'b01,
		// Counting histogram samples
		ST_ACCUM = 2'b10,
		// Emitting one lane result per cycle
		ST_DRAIN = 2'b11
	} he_state_t;

endpackage

/* he_top.sv */
// Rank-mapping engine top level
// Loads eight reference pixels, ranks the following samples against them
// and drains eight results in load order

`timescale 1ns/10ps

module he_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	input  he_pkg::pix_t    in_image,
	output logic            out_valid,
	output he_pkg::pix_t    out_image
);

	// --------------------
	// Internal wires
	// --------------------

	// Controller strobes
	logic         load_en;
	logic         clear;
	logic         count_en;
	logic         drain_en;
	he_pkg::idx_t drain_idx;

	// References out of the loader
	he_pkg::pix_t ref_pix [he_pkg::LANES];

	// Per-lane counts into the drain
	he_pkg::cnt_t rank [he_pkg::LANES];

	// --------------------
	// Control
	// --------------------

	he_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.load_en   (load_en),
		.clear     (clear),
		.count_en  (count_en),
		.drain_en  (drain_en),
		.drain_idx (drain_idx)
	);

	// Reference capture
	ref_loader u_loader (
		.clk      (clk),
		.rst_n    (rst_n),
		.load_en  (load_en),
		.in_image (in_image),
		.ref_pix  (ref_pix)
	);

	// --------------------
	// Rank lanes
	// --------------------

	// Same sample goes to every lane
	for (genvar g = 0; g < he_pkg::LANES; g++) begin : g_lane
		rank_lane u_lane (
			.clk      (clk),
			.rst_n    (rst_n),
			.clear    (clear),
			.count_en (count_en),
			.ref_pix  (ref_pix[g]),
			.sample   (in_image),
			.rank     (rank[g])
		);
	end

	// --------------------
	// Output
	// --------------------

	out_drain u_drain (
		.clk       (clk),
		.rst_n     (rst_n),
		.drain_en  (drain_en),
		.drain_idx (drain_idx),
		.rank      (rank),
		.out_valid (out_valid),
		.out_image (out_image)
	);

endmodule

/* out_drain.sv */
// Output drain
// Picks lane counts in order, subtracts one floored at zero, registers result
// out_image is held at zero outside a drain

`timescale 1ns/10ps

module out_drain (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            drain_en,
	input  he_pkg::idx_t    drain_idx,
	input  he_pkg::cnt_t    rank [he_pkg::LANES],
	output logic            out_valid,
	output he_pkg::pix_t    out_image
);

	// --------------------
	// Select and decrement
	// --------------------

	he_pkg::cnt_t sel;
	he_pkg::cnt_t dec;
	he_pkg::pix_t image_nxt;

	// Lane chosen by the controller
	assign sel = rank[drain_idx];

	// Count minus one, zero stays zero
	assign dec = (sel != '0) ? sel - 1'b1 : '0;

	// Zero between drains
	assign image_nxt = drain_en ? he_pkg::pix_t'(dec) : '0;

	// --------------------
	// Output register
	// --------------------

	// One cycle after drain_en
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_image <= '0;
		end else begin
			out_valid <= drain_en;
			out_image <= image_nxt;
		end
	end

endmodule

/* rank_lane.sv */
// Single rank lane
// Counts samples at or below the lane's reference pixel, saturating

`timescale 1ns/10ps

module rank_lane (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            clear,
	input  logic            count_en,
	input  he_pkg::pix_t    ref_pix,
	input  he_pkg::pix_t    sample,
	output he_pkg::cnt_t    rank
);

	// --------------------
	// Compare and count
	// --------------------

	logic hit;
	logic inc;

	// Sample ranks at or below reference
	assign hit = (sample <= ref_pix);

	// Stop at the limit, no wrap
	assign inc = count_en && hit && (rank < he_pkg::CNT_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rank <= '0;
		end else if (clear) begin
			// New burst wins over counting
			rank <= '0;
		end else if (inc) begin
			rank <= rank + 1'b1;
		end
	end

endmodule

/* ref_loader.sv */
// Reference pixel shift register
// Captures the first eight pixels of a burst, first pixel ends at index 0

`timescale 1ns/10ps

module ref_loader (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load_en,
	input  he_pkg::pix_t    in_image,
	output he_pkg::pix_t    ref_pix [he_pkg::LANES]
);

	// --------------------
	// Shift chain
	// --------------------

	// New pixel enters at the top, older ones move down
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < he_pkg::LANES; i++) begin
				ref_pix[i] <= '0;
			end
		end else if (load_en) begin
			for (int i = 0; i < he_pkg::LANES - 1; i++) begin
				ref_pix[i] <= ref_pix[i+1];
			end
			ref_pix[he_pkg::LANES-1] <= in_image;
		end
	end

	// Holds its contents between loads
	// Drained lanes keep reading the same references

endmodule

/* tb_he.sv */
// Testbench for the rank-mapping engine
// Drives pixel bursts, models the lane counts in software
// and checks every drained result against the model

`timescale 1ns/10ps

module tb_he;

	// --------------------
	// Limits
	// --------------------

	// Longest test is 8 refs, 300 samples and a drain, about 330 cycles
	// All five tests with gaps need under 900, so 3000 is a safe ceiling
	localparam int MAX_CYCLES = 3000;

	// Slack while waiting on out_valid
	localparam int WAIT_LIMIT = 20;

	// --------------------
	// DUT signals and bookkeeping
	// --------------------

	logic         clk;
	logic         rst_n;
	logic         in_valid;
	he_pkg::pix_t in_image;
	logic         out_valid;
	he_pkg::pix_t out_image;

	string test_name;
	int    err_cnt = 0;
	int    err_at_start;
	int    tests_pass;
	int    tests_fail;
	int    cycles = 0;

	// One counter per concurrent check
	int    run_errs = 0;
	int    img_errs = 0;
	int    res_errs = 0;

	// References, samples and expected results of one burst
	he_pkg::pix_t ref_in [he_pkg::LANES];
	he_pkg::pix_t smp_q [$];
	he_pkg::pix_t exp_res [he_pkg::LANES];

	// Position inside the current drain, sticks at 31
	logic [4:0] run_pos;

	he_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_image  (in_image),
		.out_valid (out_valid),
		.out_image (out_image)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("TIMEOUT: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Results seen so far in this drain
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_pos <= '0;
		end else if (out_valid) begin
			if (run_pos != 5'd31) begin
				run_pos <= run_pos + 1'b1;
			end
		end else begin
			run_pos <= '0;
		end
	end

	// --------------------
	// Output checks
	// --------------------

	// Drain never runs past eight results
	a_run_len: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> (run_pos < 5'd8))
	else begin
		$display("%s: out_valid stayed high for more than eight cycles", test_name);
		run_errs++;
	end

	// Idle output is zero
	a_idle_zero: assert property (@(negedge clk) disable iff (!rst_n)
		!out_valid |-> (out_image == '0))
	else begin
		$display("ERROR %s: idle out_image expected 0, actual %0d", test_name, out_image);
		img_errs++;
	end

	// Lane results in load order
	a_result: assert property (@(negedge clk) disable iff (!rst_n)
		(out_valid && run_pos < 5'd8) |-> (out_image == exp_res[run_pos[2:0]]))
	else begin
		$display("ERROR %s: lane %0d expected %0d, actual %0d",
			test_name, run_pos, exp_res[run_pos[2:0]], out_image);
		res_errs++;
	end

	// --------------------
	// Model and stimulus
	// --------------------

	function automatic int total_errs();
		return err_cnt + run_errs + img_errs + res_errs;
	endfunction

	// Count samples at or below each reference, saturate, then minus one
	task automatic build_expected();
		int cnt [he_pkg::LANES];
		for (int i = 0; i < he_pkg::LANES; i++) begin
			cnt[i] = 0;
		end
		foreach (smp_q[k]) begin
			for (int i = 0; i < he_pkg::LANES; i++) begin
				if (smp_q[k] <= ref_in[i] && cnt[i] < 255) begin
					cnt[i]++;
				end
			end
		end
		for (int i = 0; i < he_pkg::LANES; i++) begin
			exp_res[i] = (cnt[i] == 0) ? '0 : he_pkg::pix_t'(cnt[i] - 1);
		end
	endtask

	task automatic drive_pixel(input he_pkg::pix_t pix);
		@(negedge clk);
		in_valid = 1'b1;
		in_image = pix;
	endtask

	// in_valid low, junk on the data bus
	task automatic drive_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			in_valid = 1'b0;
			in_image = he_pkg::pix_t'($urandom_range(0, 255));
		end
	endtask

	task automatic fill_random_refs();
		for (int i = 0; i < he_pkg::LANES; i++) begin
			ref_in[i] = he_pkg::pix_t'($urandom_range(0, 255));
		end
	endtask

	task automatic fill_random_samples(input int n);
		smp_q.delete();
		for (int i = 0; i < n; i++) begin
			smp_q.push_back(he_pkg::pix_t'($urandom_range(0, 255)));
		end
	endtask

	// Called on the negedge that dropped in_valid
	task automatic wait_drain();
		int lat;
		int run;
		lat = 0;
		run = 0;
		while (!out_valid && lat < WAIT_LIMIT) begin
			@(negedge clk);
			lat++;
		end
		if (!out_valid) begin
			$display("%s: out_valid never rose after in_valid fell", test_name);
			err_cnt++;
		end else begin
			// One edge to leave ACCUM, one for the output register
			a_latency: assert (lat == 2) else begin
				$display("ERROR %s: drain latency expected 2, actual %0d", test_name, lat);
				err_cnt++;
			end
			while (out_valid && run < WAIT_LIMIT) begin
				@(negedge clk);
				run++;
			end
			a_length: assert (run == he_pkg::LANES) else begin
				$display("ERROR %s: drain length expected %0d, actual %0d",
					test_name, he_pkg::LANES, run);
				err_cnt++;
			end
		end
	endtask

	// References with optional gaps, then samples, then the drain
	task automatic run_burst(input int max_gap);
		build_expected();
		for (int i = 0; i < he_pkg::LANES; i++) begin
			if (i > 0 && max_gap > 0) begin
				drive_idle($urandom_range(0, max_gap));
			end
			drive_pixel(ref_in[i]);
		end
		foreach (smp_q[k]) begin
			drive_pixel(smp_q[k]);
		end
		drive_idle(1);
		wait_drain();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_at_start = total_errs();
	endtask

	task automatic end_test();
		// Late check hits land before the verdict
		drive_idle(2);
		if (total_errs() == err_at_start) begin
			tests_pass++;
			$display("PASS  %s", test_name);
		end else begin
			tests_fail++;
			$display("FAIL  %s (%0d errors)", test_name, total_errs() - err_at_start);
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		void'($urandom(24));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_image = '0;
		tests_pass = 0;
		tests_fail = 0;
		test_name = "reset";
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// Quiet outputs after reset
		begin_test("reset_idle");
		for (int i = 0; i < 12; i++) begin
			drive_idle(1);
			a_quiet: assert (out_valid == 1'b0) else begin
				$display("ERROR %s: out_valid expected 0, actual %0d", test_name, out_valid);
				err_cnt++;
			end
		end
		end_test();

		begin_test("random_burst");
		fill_random_refs();
		fill_random_samples(40);
		run_burst(0);
		end_test();

		// All counts pinned at 255
		begin_test("saturation");
		for (int i = 0; i < he_pkg::LANES; i++) begin
			ref_in[i] = 8'd255;
		end
		smp_q.delete();
		for (int i = 0; i < 300; i++) begin
			smp_q.push_back(8'd0);
		end
		run_burst(0);
		end_test();

		begin_test("empty_accum");
		fill_random_refs();
		smp_q.delete();
		run_burst(0);
		end_test();

		// Gapped load, then a fresh burst straight after the drain
		begin_test("load_gaps_reburst");
		fill_random_refs();
		fill_random_samples(30);
		run_burst(3);
		fill_random_refs();
		fill_random_samples(20);
		run_burst(3);
		end_test();

		$display("Tests: %0d passed, %0d failed, %0d errors",
			tests_pass, tests_fail, total_errs());
		if (total_errs() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
